// File: logic/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Datapath and field widths
`define CPU_XLEN          32
`define CPU_REG_IDX_W     5
`define CPU_OPCODE_W      6
`define CPU_FUNCT_W       6
`define CPU_ALU_OP_W      3

// First fetch address
`define CPU_RESET_PC      32'h0000_0000

// Primary opcodes
`define CPU_OP_RTYPE      6'h00
`define CPU_OP_BEQ        6'h04
`define CPU_OP_BNE        6'h05
`define CPU_OP_ADDIU      6'h09
`define CPU_OP_ORI        6'h0d
`define CPU_OP_LUI        6'h0f
`define CPU_OP_LW         6'h23
`define CPU_OP_SW         6'h2b

// R-type funct codes
`define CPU_FUNCT_ADDU    6'h21
`define CPU_FUNCT_SUBU    6'h23
`define CPU_FUNCT_AND     6'h24
`define CPU_FUNCT_OR      6'h25
`define CPU_FUNCT_SLT     6'h2a

// ALU operations
`define CPU_ALU_ADD       3'd0
`define CPU_ALU_SUB       3'd1
`define CPU_ALU_AND       3'd2
`define CPU_ALU_OR        3'd3
`define CPU_ALU_SLT       3'd4
`define CPU_ALU_LUI       3'd5

`endif

// File: logic/isa_pkg.sv
`include "cpu_config.svh"

package isa_pkg;

    // Data word and byte address
    typedef logic [`CPU_XLEN-1:0] word_t;
    typedef logic [`CPU_XLEN-1:0] addr_t;

    // Register number, $0 reads as zero
    typedef logic [`CPU_REG_IDX_W-1:0] reg_idx_t;

    typedef logic [`CPU_ALU_OP_W-1:0] alu_op_t;
    typedef logic [`CPU_OPCODE_W-1:0] opcode_t;
    typedef logic [`CPU_FUNCT_W-1:0]  funct_t;

    // Field split of a 32-bit instruction
    // Immediate forms reuse the low half
    typedef struct packed {
        opcode_t    opcode;
        reg_idx_t   rs;
        reg_idx_t   rt;
        reg_idx_t   rd;
        logic [4:0] shamt;
        funct_t     funct;
    } instr_t;

    // Decode result carried into execute
    typedef struct packed {
        alu_op_t  alu_op;
        reg_idx_t dest;
        logic     imm_sel;
        word_t    imm;
        logic     mem_rd;
        logic     mem_wr;
        logic     branch;
        logic     branch_ne;
        addr_t    pc4;
    } decoded_t;

endpackage

// File: logic/bus_pkg.sv
`include "cpu_config.svh"

package bus_pkg;

    // Request fields, held stable while req is high
    typedef struct packed {
        logic [`CPU_XLEN-1:0] addr;
        logic [`CPU_XLEN-1:0] wdata;
        logic                 we;
    } mem_req_t;

    // Read data, valid while ack is high
    typedef struct packed {
        logic [`CPU_XLEN-1:0] rdata;
    } mem_rsp_t;

    // Four-phase master states
    typedef enum logic [1:0] {F_IDLE, F_WAIT_ACK, F_WAIT_DROP} fetch_state_t;
    typedef enum logic [1:0] {M_IDLE, M_WAIT_ACK, M_WAIT_DROP} mem_state_t;

    // Arbiter ownership
    typedef enum logic [1:0] {ARB_IDLE, ARB_GRANT_FETCH, ARB_GRANT_DATA} arb_state_t;

endpackage

// File: logic/fetch_unit.sv
`timescale 1ns/1ps

`include "cpu_config.svh"

module fetch_unit
    import isa_pkg::*;
    import bus_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    output logic     f_req,
    input  logic     f_ack,
    output mem_req_t f_mem_req,
    input  mem_rsp_t f_rsp,
    output logic     if_valid,
    output word_t    if_instr,
    output addr_t    if_pc4,
    input  logic     id_stall,
    input  logic     redirect,
    input  addr_t    redirect_pc
);

    fetch_state_t state;
    addr_t        pc;
    addr_t        req_addr;
    word_t        fetch_data;
    logic         drop;
    logic         issue;
    logic         take;
    logic         finish;

    // New fetch whenever the bus master is free
    assign issue = (state == F_IDLE) && !redirect;
    // Decode accepts the buffered instruction
    assign take = if_valid && !id_stall;
    // Leave WAIT_DROP once ack is low and the buffer can take the word
    assign finish = (state == F_WAIT_DROP) && !f_ack &&
                    (drop || redirect || !if_valid || take);

    // Instruction reads only
    assign f_mem_req = '{addr: req_addr, wdata: '0, we: 1'b0};

    ////////////////////
    // Fetch FSM
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= F_IDLE;
            pc       <= `CPU_RESET_PC;
            f_req    <= 1'b0;
            drop     <= 1'b0;
            if_valid <= 1'b0;
        end else begin
            if (take || redirect) begin
                if_valid <= 1'b0;
            end
            case (state)
                F_IDLE: begin
                    if (issue) begin
                        f_req <= 1'b1;
                        state <= F_WAIT_ACK;
                    end
                end
                F_WAIT_ACK: begin
                    // Drop req on ack
                    if (f_ack) begin
                        f_req <= 1'b0;
                        state <= F_WAIT_DROP;
                    end
                end
                F_WAIT_DROP: begin
                    if (finish) begin
                        state <= F_IDLE;
                        drop  <= 1'b0;
                        // Stale word from before a redirect is discarded
                        if (!drop && !redirect) begin
                            if_valid <= 1'b1;
                        end
                    end
                end
                default: state <= F_IDLE;
            endcase
            // Redirect reloads the PC, any open fetch is marked stale
            if (redirect) begin
                pc <= redirect_pc;
                if (state != F_IDLE && !finish) begin
                    drop <= 1'b1;
                end
            end else if (issue) begin
                pc <= pc + 32'd4;
            end
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        if (issue) begin
            req_addr <= pc;
        end
        if (state == F_WAIT_ACK && f_ack) begin
            fetch_data <= f_rsp.rdata;
        end
        if (finish) begin
            if_instr <= fetch_data;
            if_pc4   <= req_addr + 32'd4;
        end
    end

endmodule

// File: logic/decode_stage.sv
`timescale 1ns/1ps

`include "cpu_config.svh"

module decode_stage
    import isa_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     if_valid,
    input  word_t    if_instr,
    input  addr_t    if_pc4,
    output logic     id_stall,
    output logic     ex_valid,
    output decoded_t ex_dec,
    output word_t    ex_a,
    output word_t    ex_b,
    input  logic     ex_busy,
    input  logic     flush,
    input  logic     wb_valid,
    input  reg_idx_t wb_dest,
    input  word_t    wb_data,
    input  reg_idx_t ex_dest_pending
);

    instr_t   instr;
    word_t    imm_sext;
    word_t    imm_zext;
    decoded_t dec;
    logic     use_rt;
    logic     hazard;
    word_t    rs_val;
    word_t    rt_val;
    word_t    rf [32];

    assign instr    = if_instr;
    assign imm_sext = {{16{if_instr[15]}}, if_instr[15:0]};
    assign imm_zext = {16'h0000, if_instr[15:0]};

    ////////////////////
    // Decoder
    ////////////////////

    always_comb begin
        dec        = '0;
        dec.alu_op = `CPU_ALU_ADD;
        dec.pc4    = if_pc4;
        use_rt     = 1'b0;
        case (instr.opcode)
            `CPU_OP_RTYPE: begin
                use_rt   = 1'b1;
                dec.dest = instr.rd;
                case (instr.funct)
                    `CPU_FUNCT_ADDU: dec.alu_op = `CPU_ALU_ADD;
                    `CPU_FUNCT_SUBU: dec.alu_op = `CPU_ALU_SUB;
                    `CPU_FUNCT_AND:  dec.alu_op = `CPU_ALU_AND;
                    `CPU_FUNCT_OR:   dec.alu_op = `CPU_ALU_OR;
                    `CPU_FUNCT_SLT:  dec.alu_op = `CPU_ALU_SLT;
                    // Unknown funct runs as a no-op
                    default:         dec.dest   = '0;
                endcase
            end
            `CPU_OP_ADDIU: begin
                dec.imm_sel = 1'b1;
                dec.imm     = imm_sext;
                dec.dest    = instr.rt;
            end
            `CPU_OP_ORI: begin
                dec.alu_op  = `CPU_ALU_OR;
                dec.imm_sel = 1'b1;
                dec.imm     = imm_zext;
                dec.dest    = instr.rt;
            end
            `CPU_OP_LUI: begin
                dec.alu_op  = `CPU_ALU_LUI;
                dec.imm_sel = 1'b1;
                dec.imm     = imm_zext;
                dec.dest    = instr.rt;
            end
            `CPU_OP_LW: begin
                dec.imm_sel = 1'b1;
                dec.imm     = imm_sext;
                dec.dest    = instr.rt;
                dec.mem_rd  = 1'b1;
            end
            `CPU_OP_SW: begin
                // rt carries the store data
                use_rt      = 1'b1;
                dec.imm_sel = 1'b1;
                dec.imm     = imm_sext;
                dec.mem_wr  = 1'b1;
            end
            `CPU_OP_BEQ, `CPU_OP_BNE: begin
                // Compare by subtraction, offset kept for the target
                use_rt        = 1'b1;
                dec.alu_op    = `CPU_ALU_SUB;
                dec.imm       = imm_sext;
                dec.branch    = 1'b1;
                dec.branch_ne = (instr.opcode == `CPU_OP_BNE);
            end
            default: ;
        endcase
    end

    ////////////////////
    // Register file
    ////////////////////

    // Read with $0 forced to zero and same-cycle write bypass
    function automatic word_t read_reg(reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end
        if (wb_valid && wb_dest == idx) begin
            return wb_data;
        end
        return rf[idx];
    endfunction

    always_comb begin
        rs_val = read_reg(instr.rs);
        rt_val = read_reg(instr.rt);
    end

    always_ff @(posedge clk) begin
        if (wb_valid && wb_dest != '0) begin
            rf[wb_dest] <= wb_data;
        end
    end

    // Interlock on a source still pending in execute
    assign hazard = (ex_dest_pending != '0) &&
                    ((instr.rs == ex_dest_pending) ||
                     (use_rt && instr.rt == ex_dest_pending));
    assign id_stall = hazard || ex_busy;

    ////////////////////
    // Execute hand-off
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid <= 1'b0;
        end else if (flush) begin
            ex_valid <= 1'b0;
        end else if (!ex_busy) begin
            ex_valid <= if_valid && !hazard;
        end
    end

    // Operands held while execute is busy
    always_ff @(posedge clk) begin
        if (!ex_busy) begin
            ex_dec <= dec;
            ex_a   <= rs_val;
            ex_b   <= rt_val;
        end
    end

endmodule

// File: logic/execute_stage.sv
`timescale 1ns/1ps

`include "cpu_config.svh"

module execute_stage
    import isa_pkg::*;
    import bus_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     ex_valid,
    input  decoded_t ex_dec,
    input  word_t    ex_a,
    input  word_t    ex_b,
    output logic     ex_busy,
    output reg_idx_t ex_dest_pending,
    output logic     d_req,
    input  logic     d_ack,
    output mem_req_t d_mem_req,
    input  mem_rsp_t d_rsp,
    output logic     wb_valid,
    output reg_idx_t wb_dest,
    output word_t    wb_data,
    output logic     redirect,
    output addr_t    redirect_pc
);

    mem_state_t state;
    word_t      op_b;
    word_t      alu_res;
    word_t      ld_data;
    logic       mem_done;
    logic       is_mem;

    ////////////////////
    // ALU
    ////////////////////

    assign op_b = ex_dec.imm_sel ? ex_dec.imm : ex_b;

    always_comb begin
        case (ex_dec.alu_op)
            `CPU_ALU_ADD: alu_res = ex_a + op_b;
            `CPU_ALU_SUB: alu_res = ex_a - op_b;
            `CPU_ALU_AND: alu_res = ex_a & op_b;
            `CPU_ALU_OR:  alu_res = ex_a | op_b;
            `CPU_ALU_SLT: alu_res = {{(`CPU_XLEN-1){1'b0}}, $signed(ex_a) < $signed(op_b)};
            `CPU_ALU_LUI: alu_res = {op_b[15:0], 16'h0000};
            default:      alu_res = '0;
        endcase
    end

    // Zero difference means equal operands
    assign redirect    = ex_valid && ex_dec.branch &&
                         ((alu_res == '0) != ex_dec.branch_ne);
    assign redirect_pc = ex_dec.pc4 + {ex_dec.imm[`CPU_XLEN-3:0], 2'b00};

    ////////////////////
    // Data bus master
    ////////////////////

    assign is_mem = ex_dec.mem_rd || ex_dec.mem_wr;
    // Held until the cycle after ack falls
    assign ex_busy = ex_valid && is_mem && !mem_done;
    assign ex_dest_pending = ex_busy ? ex_dec.dest : '0;

    // Word aligned access
    assign d_mem_req = '{addr: {alu_res[`CPU_XLEN-1:2], 2'b00}, wdata: ex_b, we: ex_dec.mem_wr};

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= M_IDLE;
            d_req    <= 1'b0;
            mem_done <= 1'b0;
        end else begin
            mem_done <= (state == M_WAIT_DROP) && !d_ack;
            case (state)
                M_IDLE: begin
                    if (ex_busy) begin
                        d_req <= 1'b1;
                        state <= M_WAIT_ACK;
                    end
                end
                M_WAIT_ACK: begin
                    if (d_ack) begin
                        d_req <= 1'b0;
                        state <= M_WAIT_DROP;
                    end
                end
                M_WAIT_DROP: begin
                    if (!d_ack) begin
                        state <= M_IDLE;
                    end
                end
                default: state <= M_IDLE;
            endcase
        end
    end

    // Load word captured while ack is high
    always_ff @(posedge clk) begin
        if (state == M_WAIT_ACK && d_ack) begin
            ld_data <= d_rsp.rdata;
        end
    end

    // Register write on the finishing cycle
    assign wb_valid = ex_valid && (!is_mem || mem_done) && (ex_dec.dest != '0);
    assign wb_dest  = ex_dec.dest;
    assign wb_data  = ex_dec.mem_rd ? ld_data : alu_res;

endmodule

// File: logic/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter
    import bus_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    // Fetch link
    input  logic     f_req,
    output logic     f_ack,
    input  mem_req_t f_mem_req,
    output mem_rsp_t f_rsp,
    // Data link
    input  logic     d_req,
    output logic     d_ack,
    input  mem_req_t d_mem_req,
    output mem_rsp_t d_rsp,
    // External bus
    output logic     req,
    input  logic     ack,
    output mem_req_t mem_req,
    input  mem_rsp_t mem_rsp
);

    arb_state_t state;

    ////////////////////
    // Grant FSM
    ////////////////////

    // A master cannot drop req before ack, so req and ack both low ends it
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ARB_IDLE;
        end else begin
            case (state)
                ARB_IDLE: begin
                    // Data side first
                    if (d_req) begin
                        state <= ARB_GRANT_DATA;
                    end else if (f_req) begin
                        state <= ARB_GRANT_FETCH;
                    end
                end
                ARB_GRANT_FETCH: begin
                    if (!f_req && !ack) begin
                        state <= ARB_IDLE;
                    end
                end
                ARB_GRANT_DATA: begin
                    if (!d_req && !ack) begin
                        state <= ARB_IDLE;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    // Steering to and from the owner
    always_comb begin
        req     = 1'b0;
        mem_req = '0;
        f_ack   = 1'b0;
        d_ack   = 1'b0;
        f_rsp   = '0;
        d_rsp   = '0;
        case (state)
            ARB_GRANT_FETCH: begin
                req     = f_req;
                mem_req = f_mem_req;
                f_ack   = ack;
                f_rsp   = mem_rsp;
            end
            ARB_GRANT_DATA: begin
                req     = d_req;
                mem_req = d_mem_req;
                d_ack   = ack;
                d_rsp   = mem_rsp;
            end
            default: ;
        endcase
    end

endmodule

// File: logic/cpu_core_top.sv
`timescale 1ns/1ps

module cpu_core_top
    import isa_pkg::*;
    import bus_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    output logic     req,
    input  logic     ack,
    output mem_req_t mem_req,
    input  mem_rsp_t mem_rsp
);

    // Fetch and data links into the arbiter
    logic     f_req;
    logic     f_ack;
    mem_req_t f_mem_req;
    mem_rsp_t f_rsp;
    logic     d_req;
    logic     d_ack;
    mem_req_t d_mem_req;
    mem_rsp_t d_rsp;

    // Fetch to decode
    logic     if_valid;
    word_t    if_instr;
    addr_t    if_pc4;
    logic     id_stall;

    // Decode to execute
    logic     ex_valid;
    decoded_t ex_dec;
    word_t    ex_a;
    word_t    ex_b;
    logic     ex_busy;

    // Write back, interlock and redirect
    logic     wb_valid;
    reg_idx_t wb_dest;
    word_t    wb_data;
    reg_idx_t ex_dest_pending;
    logic     redirect;
    addr_t    redirect_pc;

    fetch_unit fetch_i (
        .clk         (clk),
        .rst         (rst),
        .f_req       (f_req),
        .f_ack       (f_ack),
        .f_mem_req   (f_mem_req),
        .f_rsp       (f_rsp),
        .if_valid    (if_valid),
        .if_instr    (if_instr),
        .if_pc4      (if_pc4),
        .id_stall    (id_stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    // Redirect doubles as the decode flush
    decode_stage decode_i (
        .clk             (clk),
        .rst             (rst),
        .if_valid        (if_valid),
        .if_instr        (if_instr),
        .if_pc4          (if_pc4),
        .id_stall        (id_stall),
        .ex_valid        (ex_valid),
        .ex_dec          (ex_dec),
        .ex_a            (ex_a),
        .ex_b            (ex_b),
        .ex_busy         (ex_busy),
        .flush           (redirect),
        .wb_valid        (wb_valid),
        .wb_dest         (wb_dest),
        .wb_data         (wb_data),
        .ex_dest_pending (ex_dest_pending)
    );

    execute_stage execute_i (
        .clk             (clk),
        .rst             (rst),
        .ex_valid        (ex_valid),
        .ex_dec          (ex_dec),
        .ex_a            (ex_a),
        .ex_b            (ex_b),
        .ex_busy         (ex_busy),
        .ex_dest_pending (ex_dest_pending),
        .d_req           (d_req),
        .d_ack           (d_ack),
        .d_mem_req       (d_mem_req),
        .d_rsp           (d_rsp),
        .wb_valid        (wb_valid),
        .wb_dest         (wb_dest),
        .wb_data         (wb_data),
        .redirect        (redirect),
        .redirect_pc     (redirect_pc)
    );

    bus_arbiter arbiter_i (
        .clk       (clk),
        .rst       (rst),
        .f_req     (f_req),
        .f_ack     (f_ack),
        .f_mem_req (f_mem_req),
        .f_rsp     (f_rsp),
        .d_req     (d_req),
        .d_ack     (d_ack),
        .d_mem_req (d_mem_req),
        .d_rsp     (d_rsp),
        .req       (req),
        .ack       (ack),
        .mem_req   (mem_req),
        .mem_rsp   (mem_rsp)
    );

endmodule

// File: testbench/cpu_chk.sv
`timescale 1ns/1ps

module cpu_chk
    import bus_pkg::*;
(
    input logic     clk,
    input logic     rst,
    input logic     req,
    input logic     ack,
    input mem_req_t mem_req
);

    // Number of failed assertions
    int fail_count = 0;

    // Request fields frozen for the whole req phase
    req_stable: assert property (@(posedge clk) disable iff (rst)
        (req && $past(req)) |-> (mem_req == $past(mem_req)))
        else begin
            $error("request fields changed while req was high");
            fail_count++;
        end

    // Slave answers only to a request
    ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(ack) |-> req)
        else begin
            $error("ack rose without req");
            fail_count++;
        end

    // Master lets go only once ack is up
    req_drop_after_ack: assert property (@(posedge clk) disable iff (rst)
        $fell(req) |-> $past(ack))
        else begin
            $error("req fell before ack");
            fail_count++;
        end

    req_low_in_reset: assert property (@(posedge clk)
        (rst && $past(rst)) |-> !req)
        else begin
            $error("req high during reset");
            fail_count++;
        end

endmodule

bind cpu_core_top cpu_chk chk_i (
    .clk     (clk),
    .rst     (rst),
    .req     (req),
    .ack     (ack),
    .mem_req (mem_req)
);

// File: testbench/cpu_tb.sv
`timescale 1ns/1ps

`include "cpu_config.svh"

module cpu_tb
    import isa_pkg::*;
    import bus_pkg::*;
;

    localparam int MEM_WORDS = 1024;
    localparam addr_t DONE_ADDR = 32'h0000_0ff0;

    logic     clk;
    logic     rst;
    logic     req;
    logic     ack;
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;

    word_t       mem [MEM_WORDS];
    word_t       prog [$];
    addr_t       exp_addr [$];
    word_t       exp_data [$];
    logic [31:0] lcg_state;
    int          value_errors;
    int          other_errors;
    int          store_idx;
    logic        done;
    logic        ack_q;

    cpu_core_top dut_i (
        .clk     (clk),
        .rst     (rst),
        .req     (req),
        .ack     (ack),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Background pattern that depends on every address bit
    function automatic word_t fill_word(addr_t a);
        return (a * 32'h9e37_79b1) ^ {a[15:0], ~a[15:0]};
    endfunction

    function automatic word_t enc_r(int rs, int rt, int rd, logic [5:0] funct);
        return {`CPU_OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], 5'd0, funct};
    endfunction

    function automatic word_t enc_i(logic [5:0] op, int rs, int rt, logic [15:0] imm);
        return {op, rs[4:0], rt[4:0], imm};
    endfunction

    ////////////////////
    // ISA model
    ////////////////////

    // Runs the program and records each store in order
    function automatic void run_model();
        word_t      regs [32];
        word_t      mm [MEM_WORDS];
        addr_t      pc;
        word_t      ins;
        word_t      a;
        word_t      b;
        word_t      sx;
        word_t      zx;
        word_t      res;
        addr_t      ea;
        logic       wr;
        for (int i = 0; i < 32; i++) regs[i] = '0;
        for (int i = 0; i < MEM_WORDS; i++) mm[i] = mem[i];
        pc = `CPU_RESET_PC;
        for (int step = 0; step < 2000; step++) begin
            ins = mm[pc[11:2]];
            a   = regs[ins[25:21]];
            b   = regs[ins[20:16]];
            sx  = {{16{ins[15]}}, ins[15:0]};
            zx  = {16'h0000, ins[15:0]};
            ea  = a + sx;
            wr  = 1'b0;
            res = '0;
            pc  = pc + 4;
            case (ins[31:26])
                `CPU_OP_RTYPE: begin
                    wr = 1'b1;
                    case (ins[5:0])
                        `CPU_FUNCT_ADDU: res = a + b;
                        `CPU_FUNCT_SUBU: res = a - b;
                        `CPU_FUNCT_AND:  res = a & b;
                        `CPU_FUNCT_OR:   res = a | b;
                        `CPU_FUNCT_SLT:  res = ($signed(a) < $signed(b)) ? 1 : 0;
                        default:         wr = 1'b0;
                    endcase
                    if (wr) regs[ins[15:11]] = res;
                end
                `CPU_OP_ADDIU: regs[ins[20:16]] = a + sx;
                `CPU_OP_ORI:   regs[ins[20:16]] = a | zx;
                `CPU_OP_LUI:   regs[ins[20:16]] = {ins[15:0], 16'h0000};
                `CPU_OP_LW:    regs[ins[20:16]] = mm[ea[11:2]];
                `CPU_OP_SW: begin
                    mm[ea[11:2]] = b;
                    exp_addr.push_back({ea[31:2], 2'b00});
                    exp_data.push_back(b);
                    if ({ea[31:2], 2'b00} == DONE_ADDR) return;
                end
                `CPU_OP_BEQ: if (a == b) pc = pc + (sx << 2);
                `CPU_OP_BNE: if (a != b) pc = pc + (sx << 2);
                default: ;
            endcase
            regs[0] = '0;
        end
    endfunction

    // ALU mix, stores, load-use, branches and a counted loop
    task automatic build_program();
        prog.push_back(enc_i(`CPU_OP_ORI, 0, 1, 16'h0400));
        prog.push_back(enc_i(`CPU_OP_ADDIU, 0, 2, 16'(lcg_next() >> 16)));
        prog.push_back(enc_i(`CPU_OP_ORI, 0, 3, 16'(lcg_next() >> 16)));
        prog.push_back(enc_i(`CPU_OP_LUI, 0, 4, 16'(lcg_next() >> 16)));
        prog.push_back(enc_r(2, 3, 5, `CPU_FUNCT_ADDU));
        prog.push_back(enc_r(5, 4, 6, `CPU_FUNCT_SUBU));
        prog.push_back(enc_r(5, 6, 7, `CPU_FUNCT_AND));
        prog.push_back(enc_r(7, 4, 8, `CPU_FUNCT_OR));
        prog.push_back(enc_r(6, 5, 9, `CPU_FUNCT_SLT));
        for (int r = 2; r <= 9; r++) begin
            prog.push_back(enc_i(`CPU_OP_SW, 1, r, 16'((r - 2) * 4)));
        end
        // Load then use at once
        prog.push_back(enc_i(`CPU_OP_LW, 1, 10, 16'd4));
        prog.push_back(enc_r(10, 2, 11, `CPU_FUNCT_ADDU));
        prog.push_back(enc_i(`CPU_OP_SW, 1, 11, 16'd32));
        // Taken BEQ skips a store
        prog.push_back(enc_i(`CPU_OP_BEQ, 2, 2, 16'd1));
        prog.push_back(enc_i(`CPU_OP_SW, 1, 3, 16'd36));
        prog.push_back(enc_i(`CPU_OP_BNE, 2, 2, 16'd1));
        prog.push_back(enc_i(`CPU_OP_SW, 1, 4, 16'd40));
        prog.push_back(enc_i(`CPU_OP_BNE, 2, 3, 16'd1));
        prog.push_back(enc_i(`CPU_OP_SW, 1, 5, 16'd44));
        // Three pass loop
        prog.push_back(enc_i(`CPU_OP_ORI, 0, 12, 16'd3));
        prog.push_back(enc_i(`CPU_OP_ADDIU, 12, 12, 16'hffff));
        prog.push_back(enc_i(`CPU_OP_SW, 1, 12, 16'd48));
        prog.push_back(enc_i(`CPU_OP_BNE, 12, 0, 16'hfffd));
        prog.push_back(enc_i(`CPU_OP_ORI, 0, 13, DONE_ADDR[15:0]));
        prog.push_back(enc_i(`CPU_OP_SW, 13, 2, 16'd0));
        // Park on a self branch
        prog.push_back(enc_i(`CPU_OP_BEQ, 0, 0, 16'hffff));
    endtask

    ////////////////////
    // Memory model
    ////////////////////

    initial begin : memory_model
        int   delay;
        int   waited;
        logic [31:0] r;
        @(negedge clk);
        while (rst) @(negedge clk);
        forever begin
            waited = 0;
            while (!req && waited < 2000) begin
                @(negedge clk);
                waited++;
            end
            if (!req) begin
                if (!done) begin
                    $display("No bus request seen for %0d cycles", waited);
                    other_errors++;
                end
            end else begin
                r = lcg_next();
                delay = (r[3:0] == 4'd0) ? 12 + int'(r[7:4]) : int'(r[5:4]);
                repeat (delay) @(negedge clk);
                mem_rsp.rdata = mem[mem_req.addr[11:2]];
                if (mem_req.we) mem[mem_req.addr[11:2]] = mem_req.wdata;
                ack = 1'b1;
                waited = 0;
                @(negedge clk);
                while (req && waited < 2000) begin
                    @(negedge clk);
                    waited++;
                end
                if (req) begin
                    $display("req never dropped after ack");
                    other_errors++;
                end
                ack = 1'b0;
                @(negedge clk);
            end
        end
    end

    ////////////////////
    // Store comparator
    ////////////////////

    always @(posedge clk) begin
        ack_q <= ack;
        if (rst && req) begin
            $display("Bus request during reset");
            other_errors++;
        end
        if (ack && !ack_q && mem_req.we) begin
            if (store_idx >= exp_addr.size()) begin
                $display("Store number %0d is beyond the expected list", store_idx);
                other_errors++;
            end else begin
                if (mem_req.addr != exp_addr[store_idx]) begin
                    $display("FAILED mem_req.addr store %0d: got %h expected %h",
                             store_idx, mem_req.addr, exp_addr[store_idx]);
                    value_errors++;
                end
                if (mem_req.wdata != exp_data[store_idx]) begin
                    $display("FAILED mem_req.wdata store %0d: got %h expected %h",
                             store_idx, mem_req.wdata, exp_data[store_idx]);
                    value_errors++;
                end
            end
            store_idx++;
            if (mem_req.addr == DONE_ADDR) done <= 1'b1;
        end
    end

    initial begin : main
        int cycles;
        rst          = 1'b1;
        ack          = 1'b0;
        mem_rsp      = '0;
        lcg_state    = 32'h938c;
        value_errors = 0;
        other_errors = 0;
        store_idx    = 0;
        done         = 1'b0;
        ack_q        = 1'b0;
        build_program();
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = (i < prog.size()) ? prog[i] : fill_word(addr_t'(i * 4));
        end
        run_model();
        repeat (10) @(negedge clk);
        rst = 1'b0;
        cycles = 0;
        while (!done && cycles < 200000) begin
            @(negedge clk);
            cycles++;
        end
        if (!done) begin
            $display("Timeout waiting for the completion store");
            $display("Errors: value %0d, other %0d, assertion %0d",
                     value_errors, other_errors, dut_i.chk_i.fail_count);
            $display("Test failed");
            $finish;
        end else begin
            repeat (4) @(negedge clk);
            if (store_idx != exp_addr.size()) begin
                $display("Saw %0d stores but the model made %0d", store_idx, exp_addr.size());
                other_errors++;
            end
            $display("Errors: value %0d, other %0d, assertion %0d",
                     value_errors, other_errors, dut_i.chk_i.fail_count);
            if (value_errors == 0 && other_errors == 0 && dut_i.chk_i.fail_count == 0) begin
                $display("Test completed successfully");
            end else begin
                $display("Test failed");
            end
            $finish;
        end
    end

endmodule

// File: build.f
+incdir+logic
logic/isa_pkg.sv
logic/bus_pkg.sv
logic/fetch_unit.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/bus_arbiter.sv
logic/cpu_core_top.sv
testbench/cpu_chk.sv
testbench/cpu_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= Test completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
